//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = core_tb
FILELIST  = tiny_rv.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: compile
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(OBJ_DIR)

//--- src/core.sv
`timescale 1ns/1ps
`default_nettype none

module core #(
	parameter rv_pkg::word_t reset_pc = '0
) (
	input  wire logic          clk,
	input  wire logic          rst_n,
	output logic               inst_start,
	input  wire logic          inst_ready,
	output rv_pkg::word_t      inst_addr,
	input  wire rv_pkg::word_t inst_data,
	input  wire logic          inst_valid,
	output logic               data_start,
	output logic               data_write,
	input  wire logic          data_ready,
	output rv_pkg::word_t      data_addr,
	output rv_pkg::word_t      data_wdata,
	input  wire rv_pkg::word_t data_rdata,
	input  wire logic          data_valid
);

	// ****************************************
	// control against the flow
	// ****************************************
	logic              mem_stall;
	logic              decode_hold;
	logic              flush;
	rv_pkg::word_t     redirect_pc;

	// fetch to decode
	logic              id_valid;
	rv_pkg::word_t     id_pc;
	rv_pkg::word_t     id_inst;

	// register file
	rv_pkg::reg_addr_t rs1;
	rv_pkg::reg_addr_t rs2;
	rv_pkg::word_t     rs1_data;
	rv_pkg::word_t     rs2_data;
	logic              rf_wen;
	rv_pkg::reg_addr_t rf_rd;
	rv_pkg::word_t     rf_wdata;

	// ****************************************
	// stage registers
	// ****************************************
	logic              ex_valid;
	rv_pkg::word_t     ex_pc;
	rv_pkg::word_t     ex_op1;
	rv_pkg::word_t     ex_op2;
	rv_pkg::word_t     ex_store_data;
	rv_pkg::alu_op_t   ex_alu_op;
	rv_pkg::wb_sel_t   ex_wb_sel;
	rv_pkg::br_kind_t  ex_br_kind;
	rv_pkg::reg_addr_t ex_rd;
	logic              ex_rf_wen;
	logic              ex_mem_read;
	logic              ex_mem_write;
	rv_pkg::word_t     ex_br_imm;

	logic              mem_valid;
	rv_pkg::word_t     mem_pc;
	rv_pkg::word_t     mem_alu_out;
	rv_pkg::word_t     mem_store_data;
	logic              mem_br_taken;
	rv_pkg::word_t     mem_br_target;
	rv_pkg::wb_sel_t   mem_wb_sel;
	rv_pkg::reg_addr_t mem_rd;
	logic              mem_rf_wen;
	logic              mem_mem_read;
	logic              mem_mem_write;

	logic              wb_valid;
	rv_pkg::word_t     wb_pc;
	rv_pkg::word_t     wb_alu_out;
	rv_pkg::word_t     wb_rdata;
	logic              wb_br_taken;
	rv_pkg::word_t     wb_br_target;
	rv_pkg::wb_sel_t   wb_wb_sel;
	rv_pkg::reg_addr_t wb_rd;
	logic              wb_rf_wen;

	// names line up across stages
	fetch_stage #(
		.reset_pc(reset_pc)
	) u_fetch (.*);

	reg_file u_reg_file (
		.*,
		.wen(rf_wen),
		.rd(rf_rd),
		.wdata(rf_wdata)
	);

	decode_stage u_decode (.*);

	execute_stage u_execute (.*);

	memory_stage u_memory (.*);

	writeback_stage u_writeback (.*);

endmodule

`default_nettype wire

//--- src/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire logic              mem_stall,
	input  wire logic              flush,
	input  wire logic              id_valid,
	input  wire rv_pkg::word_t     id_pc,
	input  wire rv_pkg::word_t     id_inst,
	output rv_pkg::reg_addr_t      rs1,
	output rv_pkg::reg_addr_t      rs2,
	input  wire rv_pkg::word_t     rs1_data,
	input  wire rv_pkg::word_t     rs2_data,
	input  wire rv_pkg::reg_addr_t mem_rd,
	input  wire logic              mem_rf_wen,
	input  wire rv_pkg::reg_addr_t wb_rd,
	input  wire logic              wb_rf_wen,
	output logic                   decode_hold,
	output logic                   ex_valid,
	output rv_pkg::word_t          ex_pc,
	output rv_pkg::word_t          ex_op1,
	output rv_pkg::word_t          ex_op2,
	output rv_pkg::word_t          ex_store_data,
	output rv_pkg::alu_op_t        ex_alu_op,
	output rv_pkg::wb_sel_t        ex_wb_sel,
	output rv_pkg::br_kind_t       ex_br_kind,
	output rv_pkg::reg_addr_t      ex_rd,
	output logic                   ex_rf_wen,
	output logic                   ex_mem_read,
	output logic                   ex_mem_write,
	output rv_pkg::word_t          ex_br_imm
);

	rv_pkg::word_t    inst;
	logic [6:0]       opcode;
	logic [2:0]       funct3;
	logic [6:0]       funct7;
	logic [6:0]       id_op;
	logic             uses_rs1;
	logic             uses_rs2;
	logic             rs1_busy;
	logic             rs2_busy;
	rv_pkg::word_t    imm_i;
	rv_pkg::word_t    imm_s;
	rv_pkg::word_t    imm_b;
	rv_pkg::word_t    imm_j;
	rv_pkg::word_t    imm_u;
	rv_pkg::word_t    op2;
	rv_pkg::word_t    br_imm;
	rv_pkg::alu_op_t  alu_op;
	rv_pkg::wb_sel_t  wb_sel;
	rv_pkg::br_kind_t br_kind;
	logic             rf_wen;
	logic             mem_read;
	logic             mem_write;

	// ****************************************
	// hazard interlock
	// ****************************************
	assign rs1   = id_inst[19:15];
	assign rs2   = id_inst[24:20];
	assign id_op = id_inst[6:0];

	assign uses_rs1 = id_op != rv_pkg::op_lui && id_op != rv_pkg::op_jal;
	assign uses_rs2 = id_op == rv_pkg::op_reg || id_op == rv_pkg::op_store ||
		id_op == rv_pkg::op_branch;

	assign rs1_busy = (ex_rf_wen && ex_rd == rs1) || (mem_rf_wen && mem_rd == rs1) ||
		(wb_rf_wen && wb_rd == rs1);
	assign rs2_busy = (ex_rf_wen && ex_rd == rs2) || (mem_rf_wen && mem_rd == rs2) ||
		(wb_rf_wen && wb_rd == rs2);

	assign decode_hold = id_valid && ((uses_rs1 && rs1 != 5'd0 && rs1_busy) ||
		(uses_rs2 && rs2 != 5'd0 && rs2_busy));

	// ****************************************
	// instruction decode
	// ****************************************
	assign inst   = (id_valid && !decode_hold) ? id_inst : rv_pkg::nop_inst;
	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};

	// anything unknown falls through with no side effects
	always_comb begin
		alu_op    = rv_pkg::alu_add;
		wb_sel    = rv_pkg::wb_alu;
		br_kind   = rv_pkg::br_none;
		rf_wen    = 1'b0;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		op2       = rs2_data;
		br_imm    = imm_b;
		case (opcode)
			rv_pkg::op_reg: begin
				rf_wen = funct7 == 7'h00 || (funct7 == 7'h20 && funct3 == 3'b000);
				case (funct3)
					3'b000: alu_op = funct7[5] ? rv_pkg::alu_sub : rv_pkg::alu_add;
					3'b010: alu_op = rv_pkg::alu_slt;
					3'b100: alu_op = rv_pkg::alu_xor;
					3'b110: alu_op = rv_pkg::alu_or;
					3'b111: alu_op = rv_pkg::alu_and;
					default: rf_wen = 1'b0;
				endcase
			end
			rv_pkg::op_imm: begin
				op2    = imm_i;
				rf_wen = funct3 == 3'b000;
			end
			rv_pkg::op_lui: begin
				op2    = imm_u;
				alu_op = rv_pkg::alu_pass_b;
				rf_wen = 1'b1;
			end
			rv_pkg::op_load: begin
				op2      = imm_i;
				wb_sel   = rv_pkg::wb_mem;
				rf_wen   = funct3 == 3'b010;
				mem_read = funct3 == 3'b010;
			end
			rv_pkg::op_store: begin
				op2       = imm_s;
				mem_write = funct3 == 3'b010;
			end
			rv_pkg::op_branch: begin
				if (funct3 == 3'b000) begin
					br_kind = rv_pkg::br_beq;
				end else if (funct3 == 3'b001) begin
					br_kind = rv_pkg::br_bne;
				end
			end
			rv_pkg::op_jal: begin
				br_kind = rv_pkg::br_jal;
				br_imm  = imm_j;
				wb_sel  = rv_pkg::wb_pc_plus4;
				rf_wen  = 1'b1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_valid     <= 1'b0;
			ex_rf_wen    <= 1'b0;
			ex_mem_read  <= 1'b0;
			ex_mem_write <= 1'b0;
			ex_br_kind   <= rv_pkg::br_none;
		end else if (flush) begin
			ex_valid     <= 1'b0;
			ex_rf_wen    <= 1'b0;
			ex_mem_read  <= 1'b0;
			ex_mem_write <= 1'b0;
			ex_br_kind   <= rv_pkg::br_none;
		end else if (!mem_stall) begin
			ex_valid     <= id_valid && !decode_hold;
			ex_rf_wen    <= rf_wen;
			ex_mem_read  <= mem_read;
			ex_mem_write <= mem_write;
			ex_br_kind   <= br_kind;
		end
	end

	always_ff @(posedge clk) begin
		if (!mem_stall) begin
			ex_pc         <= id_pc;
			ex_op1        <= rs1_data;
			ex_op2        <= op2;
			ex_store_data <= rs2_data;
			ex_alu_op     <= alu_op;
			ex_wb_sel     <= wb_sel;
			ex_rd         <= inst[11:7];
			ex_br_imm     <= br_imm;
		end
	end

endmodule

`default_nettype wire

//--- src/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire logic              mem_stall,
	input  wire logic              flush,
	input  wire logic              ex_valid,
	input  wire rv_pkg::word_t     ex_pc,
	input  wire rv_pkg::word_t     ex_op1,
	input  wire rv_pkg::word_t     ex_op2,
	input  wire rv_pkg::word_t     ex_store_data,
	input  wire rv_pkg::alu_op_t   ex_alu_op,
	input  wire rv_pkg::wb_sel_t   ex_wb_sel,
	input  wire rv_pkg::br_kind_t  ex_br_kind,
	input  wire rv_pkg::reg_addr_t ex_rd,
	input  wire logic              ex_rf_wen,
	input  wire logic              ex_mem_read,
	input  wire logic              ex_mem_write,
	input  wire rv_pkg::word_t     ex_br_imm,
	output logic                   mem_valid,
	output rv_pkg::word_t          mem_pc,
	output rv_pkg::word_t          mem_alu_out,
	output rv_pkg::word_t          mem_store_data,
	output logic                   mem_br_taken,
	output rv_pkg::word_t          mem_br_target,
	output rv_pkg::wb_sel_t        mem_wb_sel,
	output rv_pkg::reg_addr_t      mem_rd,
	output logic                   mem_rf_wen,
	output logic                   mem_mem_read,
	output logic                   mem_mem_write
);

	rv_pkg::word_t alu_res;
	logic          taken;

	always_comb begin
		case (ex_alu_op)
			rv_pkg::alu_add: alu_res = ex_op1 + ex_op2;
			rv_pkg::alu_sub: alu_res = ex_op1 - ex_op2;
			rv_pkg::alu_and: alu_res = ex_op1 & ex_op2;
			rv_pkg::alu_or:  alu_res = ex_op1 | ex_op2;
			rv_pkg::alu_xor: alu_res = ex_op1 ^ ex_op2;
			rv_pkg::alu_slt: alu_res = {31'b0, $signed(ex_op1) < $signed(ex_op2)};
			default:         alu_res = ex_op2;
		endcase
	end

	// op2 carries rs2 for branches
	always_comb begin
		case (ex_br_kind)
			rv_pkg::br_beq: taken = ex_op1 == ex_op2;
			rv_pkg::br_bne: taken = ex_op1 != ex_op2;
			rv_pkg::br_jal: taken = 1'b1;
			default:        taken = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_valid     <= 1'b0;
			mem_br_taken  <= 1'b0;
			mem_rf_wen    <= 1'b0;
			mem_mem_read  <= 1'b0;
			mem_mem_write <= 1'b0;
		end else if (flush) begin
			mem_valid     <= 1'b0;
			mem_br_taken  <= 1'b0;
			mem_rf_wen    <= 1'b0;
			mem_mem_read  <= 1'b0;
			mem_mem_write <= 1'b0;
		end else if (!mem_stall) begin
			mem_valid     <= ex_valid;
			mem_br_taken  <= ex_valid && taken;
			mem_rf_wen    <= ex_rf_wen;
			mem_mem_read  <= ex_mem_read;
			mem_mem_write <= ex_mem_write;
		end
	end

	always_ff @(posedge clk) begin
		if (!mem_stall) begin
			mem_pc         <= ex_pc;
			mem_alu_out    <= alu_res;
			mem_store_data <= ex_store_data;
			mem_br_target  <= ex_pc + ex_br_imm;
			mem_wb_sel     <= ex_wb_sel;
			mem_rd         <= ex_rd;
		end
	end

endmodule

`default_nettype wire

//--- src/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
	parameter rv_pkg::word_t reset_pc = '0
) (
	input  wire logic          clk,
	input  wire logic          rst_n,
	input  wire logic          mem_stall,
	input  wire logic          decode_hold,
	input  wire logic          flush,
	input  wire rv_pkg::word_t redirect_pc,
	output logic               inst_start,
	input  wire logic          inst_ready,
	output rv_pkg::word_t      inst_addr,
	input  wire rv_pkg::word_t inst_data,
	input  wire logic          inst_valid,
	output logic               id_valid,
	output rv_pkg::word_t      id_pc,
	output rv_pkg::word_t      id_inst
);

	rv_pkg::word_t pc;
	logic          pend;
	logic          discard;
	logic          buf_valid;
	rv_pkg::word_t buf_inst;
	rv_pkg::word_t buf_pc;
	logic          accept;
	logic          resp;
	logic          keep;
	logic          issue;
	logic          id_take;

	assign accept  = inst_start && inst_ready;
	assign resp    = pend && inst_valid;
	assign keep    = resp && !discard && !flush;
	// one request in flight, and only with room for its answer
	assign issue   = !inst_start && !pend && !buf_valid && !flush;
	assign id_take = !id_valid || (!mem_stall && !decode_hold);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc         <= reset_pc;
			inst_addr  <= reset_pc;
			inst_start <= 1'b0;
			pend       <= 1'b0;
			discard    <= 1'b0;
		end else begin
			if (issue) begin
				inst_start <= 1'b1;
				inst_addr  <= pc;
				pc         <= pc + 32'd4;
			end else if (accept) begin
				inst_start <= 1'b0;
			end
			if (accept) begin
				pend <= 1'b1;
			end else if (resp) begin
				pend <= 1'b0;
			end
			// answer to a cancelled request is thrown away
			if (flush) begin
				pc      <= redirect_pc;
				discard <= (inst_start || pend) && !resp;
			end else if (resp) begin
				discard <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_valid  <= 1'b0;
			buf_valid <= 1'b0;
		end else if (flush) begin
			id_valid  <= 1'b0;
			buf_valid <= 1'b0;
		end else if (id_take) begin
			id_valid  <= buf_valid || keep;
			buf_valid <= 1'b0;
		end else if (keep) begin
			buf_valid <= 1'b1;
		end
	end

	// buffered word is older than anything arriving now
	always_ff @(posedge clk) begin
		if (id_take) begin
			id_inst <= buf_valid ? buf_inst : inst_data;
			id_pc   <= buf_valid ? buf_pc : inst_addr;
		end
		if (keep && !id_take) begin
			buf_inst <= inst_data;
			buf_pc   <= inst_addr;
		end
	end

endmodule

`default_nettype wire

//--- src/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory_stage (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire logic              flush,
	input  wire logic              mem_valid,
	input  wire rv_pkg::word_t     mem_pc,
	input  wire rv_pkg::word_t     mem_alu_out,
	input  wire rv_pkg::word_t     mem_store_data,
	input  wire logic              mem_br_taken,
	input  wire rv_pkg::word_t     mem_br_target,
	input  wire rv_pkg::wb_sel_t   mem_wb_sel,
	input  wire rv_pkg::reg_addr_t mem_rd,
	input  wire logic              mem_rf_wen,
	input  wire logic              mem_mem_read,
	input  wire logic              mem_mem_write,
	output logic                   data_start,
	output logic                   data_write,
	input  wire logic              data_ready,
	output rv_pkg::word_t          data_addr,
	output rv_pkg::word_t          data_wdata,
	input  wire rv_pkg::word_t     data_rdata,
	input  wire logic              data_valid,
	output logic                   mem_stall,
	output logic                   wb_valid,
	output rv_pkg::word_t          wb_pc,
	output rv_pkg::word_t          wb_alu_out,
	output rv_pkg::word_t          wb_rdata,
	output logic                   wb_br_taken,
	output rv_pkg::word_t          wb_br_target,
	output rv_pkg::wb_sel_t        wb_wb_sel,
	output rv_pkg::reg_addr_t      wb_rd,
	output logic                   wb_rf_wen
);

	typedef enum logic [1:0] {
		st_idle,
		st_request,
		st_wait_data
	} state_t;

	state_t state;
	state_t state_next;
	logic   access;

	assign access = mem_valid && (mem_mem_read || mem_mem_write);

	// request fields come straight from the frozen input register
	assign data_start = state == st_request;
	assign data_write = mem_mem_write;
	assign data_addr  = mem_alu_out;
	assign data_wdata = mem_store_data;

	// a flushed access never starts, so flush and stall never overlap
	always_comb begin
		state_next = state;
		mem_stall  = 1'b0;
		case (state)
			st_idle: begin
				if (access && !flush) begin
					state_next = st_request;
					mem_stall  = 1'b1;
				end
			end
			st_request: begin
				mem_stall = 1'b1;
				if (data_ready && data_write) begin
					state_next = st_idle;
					mem_stall  = 1'b0;
				end else if (data_ready) begin
					state_next = st_wait_data;
				end
			end
			st_wait_data: begin
				mem_stall = !data_valid;
				if (data_valid) begin
					state_next = st_idle;
				end
			end
			default: state_next = st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid    <= 1'b0;
			wb_br_taken <= 1'b0;
			wb_rf_wen   <= 1'b0;
		end else if (flush) begin
			wb_valid    <= 1'b0;
			wb_br_taken <= 1'b0;
			wb_rf_wen   <= 1'b0;
		end else if (!mem_stall) begin
			wb_valid    <= mem_valid;
			wb_br_taken <= mem_br_taken;
			wb_rf_wen   <= mem_rf_wen;
		end
	end

	always_ff @(posedge clk) begin
		if (!mem_stall) begin
			wb_pc        <= mem_pc;
			wb_alu_out   <= mem_alu_out;
			wb_br_target <= mem_br_target;
			wb_wb_sel    <= mem_wb_sel;
			wb_rd        <= mem_rd;
		end
		if (state == st_wait_data && data_valid) begin
			wb_rdata <= data_rdata;
		end
	end

endmodule

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  wire logic              clk,
	input  wire logic              rst_n,
	input  wire rv_pkg::reg_addr_t rs1,
	input  wire rv_pkg::reg_addr_t rs2,
	output rv_pkg::word_t          rs1_data,
	output rv_pkg::word_t          rs2_data,
	input  wire logic              wen,
	input  wire rv_pkg::reg_addr_t rd,
	input  wire rv_pkg::word_t     wdata
);

	// x0 has no storage
	rv_pkg::word_t regs [1:31];

	assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && rd != 5'd0) begin
			regs[rd] <= wdata;
		end
	end

endmodule

`default_nettype wire

//--- src/rv_pkg.sv
`default_nettype none

package rv_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_pass_b
	} alu_op_t;

	// writeback source
	typedef enum logic [1:0] {
		wb_alu,
		wb_mem,
		wb_pc_plus4
	} wb_sel_t;

	typedef enum logic [1:0] {
		br_none,
		br_beq,
		br_bne,
		br_jal
	} br_kind_t;

	// base opcodes of the supported subset
	localparam logic [6:0] op_reg    = 7'b0110011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal    = 7'b1101111;

	// addi x0, x0, 0
	localparam word_t nop_inst = 32'h0000_0013;

endpackage

`default_nettype wire

//--- src/writeback_stage.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
	input  wire logic              wb_valid,
	input  wire rv_pkg::word_t     wb_pc,
	input  wire rv_pkg::word_t     wb_alu_out,
	input  wire rv_pkg::word_t     wb_rdata,
	input  wire logic              wb_br_taken,
	input  wire rv_pkg::word_t     wb_br_target,
	input  wire rv_pkg::wb_sel_t   wb_wb_sel,
	input  wire rv_pkg::reg_addr_t wb_rd,
	input  wire logic              wb_rf_wen,
	output logic                   rf_wen,
	output rv_pkg::reg_addr_t      rf_rd,
	output rv_pkg::word_t          rf_wdata,
	output logic                   flush,
	output rv_pkg::word_t          redirect_pc
);

	assign rf_wen = wb_valid && wb_rf_wen;
	assign rf_rd  = wb_rd;

	always_comb begin
		case (wb_wb_sel)
			rv_pkg::wb_mem:      rf_wdata = wb_rdata;
			rv_pkg::wb_pc_plus4: rf_wdata = wb_pc + 32'd4;
			default:             rf_wdata = wb_alu_out;
		endcase
	end

	// taken branch kills everything younger
	assign flush       = wb_valid && wb_br_taken;
	assign redirect_pc = wb_br_target;

endmodule

`default_nettype wire

//--- tiny_rv.f
src/rv_pkg.sv
src/fetch_stage.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/writeback_stage.sv
src/core.sv
verif/core_assert.sv
verif/core_tb.sv

//--- verif/core_assert.sv
`timescale 1ns/1ps
`default_nettype none

module core_assert (
	input  wire logic          clk,
	input  wire logic          rst_n,
	input  wire logic          inst_start,
	input  wire logic          inst_ready,
	input  wire rv_pkg::word_t inst_addr,
	input  wire logic          data_start,
	input  wire logic          data_write,
	input  wire logic          data_ready,
	input  wire rv_pkg::word_t data_addr,
	input  wire rv_pkg::word_t data_wdata,
	input  wire logic          data_valid,
	input  wire logic          flush,
	input  wire logic          mem_stall
);

	// one read accepted and not yet answered
	logic read_open;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			read_open <= 1'b0;
		end else if (data_start && data_ready && !data_write) begin
			read_open <= 1'b1;
		end else if (data_valid) begin
			read_open <= 1'b0;
		end
	end

	inst_hold: assert property (@(posedge clk) disable iff (!rst_n)
		inst_start && !inst_ready |=> inst_start && $stable(inst_addr))
		else $error("instruction request dropped or moved before ready");

	data_hold: assert property (@(posedge clk) disable iff (!rst_n)
		data_start && !data_ready |=> data_start && $stable(data_addr) &&
		$stable(data_write) && $stable(data_wdata))
		else $error("data request dropped or changed before ready");

	valid_open: assert property (@(posedge clk) disable iff (!rst_n)
		data_valid |-> read_open)
		else $error("data_valid with no read outstanding");

	no_flush_in_stall: assert property (@(posedge clk) disable iff (!rst_n)
		!(flush && mem_stall))
		else $error("flush raised while the pipeline is frozen");

endmodule

bind core core_assert u_core_assert (.*);

`default_nettype wire

//--- verif/core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module core_tb;

	localparam rv_pkg::word_t reset_pc = 32'h0000_0100;
	localparam int prog_len = 200;
	localparam int halt_idx = prog_len - 1;
	// random body, then eight closing stores, then the halt loop
	localparam int body_len = prog_len - 9;
	localparam rv_pkg::word_t halt_pc = reset_pc + 32'(4 * halt_idx);
	localparam int max_cycles = prog_len * 10 * 4 + 100;

	typedef enum int {
		k_add, k_sub, k_and, k_or, k_xor, k_slt, k_addi,
		k_lui, k_lw, k_sw, k_beq, k_bne, k_jal
	} kind_t;

	logic          clk;
	logic          rst_n;
	logic          inst_start;
	logic          inst_ready;
	rv_pkg::word_t inst_addr;
	rv_pkg::word_t inst_data;
	logic          inst_valid;
	logic          data_start;
	logic          data_write;
	logic          data_ready;
	rv_pkg::word_t data_addr;
	rv_pkg::word_t data_wdata;
	rv_pkg::word_t data_rdata;
	logic          data_valid;

	rv_pkg::word_t prog [0:prog_len-1];
	kind_t         kind [0:prog_len-1];
	logic [4:0]    f_rd [0:prog_len-1];
	logic [4:0]    f_rs1 [0:prog_len-1];
	logic [4:0]    f_rs2 [0:prog_len-1];
	rv_pkg::word_t f_imm [0:prog_len-1];
	rv_pkg::word_t dmem [0:63];
	rv_pkg::word_t exp_addr [$];
	rv_pkg::word_t exp_data [$];
	logic [31:0]   lfsr;
	int            cycles;
	int            store_cnt;
	logic          stores_done;
	logic          halt_seen;
	logic          first_fetch;
	int            i_wait;
	int            i_delay;
	logic          i_busy;
	rv_pkg::word_t i_addr;
	int            d_wait;
	int            d_delay;
	logic          d_busy;
	rv_pkg::word_t d_addr;

	core #(
		.reset_pc(reset_pc)
	) UUT (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int b = 0; b < n; b++) begin
			lfsr = lfsr_step(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// mixes every address bit into the word
	function automatic rv_pkg::word_t fill_word(input rv_pkg::word_t addr);
		return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
	endfunction

	function automatic rv_pkg::word_t fetch_word(input rv_pkg::word_t addr);
		rv_pkg::word_t idx;
		idx = (addr - reset_pc) >> 2;
		if (addr < reset_pc || idx >= prog_len) begin
			return 32'h0000_0013;
		end else begin
			return prog[idx];
		end
	endfunction

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input rv_pkg::word_t expected,
		input rv_pkg::word_t actual);
		if (actual !== expected) begin
			stop_with_failure($sformatf("Fail %s: expected %h, actual %h",
				name, expected, actual));
		end
	endtask

	// ****************************************
	// program generator and encoder
	// ****************************************
	function automatic rv_pkg::word_t encode_inst(input int i);
		logic [4:0]    rd;
		logic [4:0]    rs1;
		logic [4:0]    rs2;
		rv_pkg::word_t m;
		rd  = f_rd[i];
		rs1 = f_rs1[i];
		rs2 = f_rs2[i];
		m   = f_imm[i];
		case (kind[i])
			k_add:  return {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
			k_sub:  return {7'h20, rs2, rs1, 3'b000, rd, 7'b0110011};
			k_and:  return {7'h00, rs2, rs1, 3'b111, rd, 7'b0110011};
			k_or:   return {7'h00, rs2, rs1, 3'b110, rd, 7'b0110011};
			k_xor:  return {7'h00, rs2, rs1, 3'b100, rd, 7'b0110011};
			k_slt:  return {7'h00, rs2, rs1, 3'b010, rd, 7'b0110011};
			k_addi: return {m[11:0], rs1, 3'b000, rd, 7'b0010011};
			k_lui:  return {m[31:12], rd, 7'b0110111};
			k_lw:   return {m[11:0], rs1, 3'b010, rd, 7'b0000011};
			k_sw:   return {m[11:5], rs2, rs1, 3'b010, m[4:0], 7'b0100011};
			k_beq:  return {m[12], m[10:5], rs2, rs1, 3'b000, m[4:1], m[11], 7'b1100011};
			k_bne:  return {m[12], m[10:5], rs2, rs1, 3'b001, m[4:1], m[11], 7'b1100011};
			default: return {m[20], m[10:1], m[11], m[19:12], rd, 7'b1101111};
		endcase
	endfunction

	task automatic build_program();
		rv_pkg::word_t r;
		int            tgt;
		for (int i = 0; i < body_len; i++) begin
			kind[i]  = kind_t'(rand_bits(4) % 13);
			f_rd[i]  = 5'(rand_bits(3));
			f_rs1[i] = 5'(rand_bits(3));
			f_rs2[i] = 5'(rand_bits(3));
			f_imm[i] = '0;
			case (kind[i])
				k_addi: begin
					r        = rand_bits(12);
					f_imm[i] = {{20{r[11]}}, r[11:0]};
				end
				k_lui: begin
					r        = rand_bits(20);
					f_imm[i] = {r[19:0], 12'h000};
				end
				k_lw, k_sw: begin
					f_rs1[i] = 5'd0;
					f_imm[i] = 32'h400 + (rand_bits(6) << 2);
				end
				k_beq, k_bne, k_jal: begin
					// forward only, never past the closing stores
					tgt = i + 1 + int'(rand_bits(3));
					if (tgt > body_len) begin
						tgt = body_len;
					end
					f_imm[i] = rv_pkg::word_t'(4 * (tgt - i));
				end
				default: ;
			endcase
		end
		for (int k = 0; k < 8; k++) begin
			kind[body_len + k]  = k_sw;
			f_rd[body_len + k]  = 5'd0;
			f_rs1[body_len + k] = 5'd0;
			f_rs2[body_len + k] = 5'(k);
			f_imm[body_len + k] = 32'h4e0 + 32'(4 * k);
		end
		kind[halt_idx]  = k_jal;
		f_rd[halt_idx]  = 5'd0;
		f_rs1[halt_idx] = 5'd0;
		f_rs2[halt_idx] = 5'd0;
		f_imm[halt_idx] = '0;
		for (int i = 0; i < prog_len; i++) begin
			prog[i] = encode_inst(i);
		end
	endtask

	// ****************************************
	// reference instruction model
	// ****************************************
	task automatic run_model();
		rv_pkg::word_t x [0:31];
		rv_pkg::word_t mem [0:63];
		rv_pkg::word_t a;
		rv_pkg::word_t b;
		rv_pkg::word_t addr;
		rv_pkg::word_t res;
		logic          wr;
		int            i;
		int            nxt;
		for (int r = 0; r < 32; r++) begin
			x[r] = '0;
		end
		for (int w = 0; w < 64; w++) begin
			mem[w] = fill_word(32'h400 + 32'(4 * w));
		end
		i = 0;
		while (i != halt_idx) begin
			a    = x[f_rs1[i]];
			b    = x[f_rs2[i]];
			addr = a + f_imm[i];
			res  = '0;
			wr   = 1'b1;
			nxt  = i + 1;
			case (kind[i])
				k_add:  res = a + b;
				k_sub:  res = a - b;
				k_and:  res = a & b;
				k_or:   res = a | b;
				k_xor:  res = a ^ b;
				k_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				k_addi: res = addr;
				k_lui:  res = f_imm[i];
				k_lw:   res = mem[addr[7:2]];
				k_sw: begin
					wr              = 1'b0;
					mem[addr[7:2]] = b;
					exp_addr.push_back(addr);
					exp_data.push_back(b);
				end
				k_beq, k_bne: begin
					wr = 1'b0;
					if ((a == b) == (kind[i] == k_beq)) begin
						nxt = i + int'(f_imm[i] >> 2);
					end
				end
				// jal links the next pc
				default: begin
					res = reset_pc + 32'(4 * i + 4);
					nxt = i + int'(f_imm[i] >> 2);
				end
			endcase
			if (wr) begin
				x[f_rd[i]] = res;
			end
			x[0] = '0;
			i    = nxt;
		end
	endtask

	task automatic take_store(input rv_pkg::word_t addr, input rv_pkg::word_t wdata);
		if (exp_addr.size() == 0) begin
			stop_with_failure($sformatf("store to %h arrived after the last expected store",
				addr));
		end else begin
			check_value($sformatf("store %0d address", store_cnt), exp_addr.pop_front(), addr);
			check_value($sformatf("store %0d data", store_cnt), exp_data.pop_front(), wdata);
			dmem[addr[7:2]] = wdata;
			store_cnt++;
			stores_done = exp_addr.size() == 0;
		end
	endtask

	// ****************************************
	// memory models, driven on the falling edge
	// ****************************************
	always @(negedge clk) begin
		inst_ready = 1'b0;
		inst_valid = 1'b0;
		data_ready = 1'b0;
		data_valid = 1'b0;
		if (i_busy) begin
			if (i_delay == 0) begin
				inst_valid = 1'b1;
				inst_data  = fetch_word(i_addr);
				i_busy     = 1'b0;
			end else begin
				i_delay--;
			end
		end else if (inst_start) begin
			if (!first_fetch) begin
				check_value("first fetch address", reset_pc, inst_addr);
				first_fetch = 1'b1;
			end
			if (i_wait == 0) begin
				inst_ready = 1'b1;
				i_addr     = inst_addr;
				i_busy     = 1'b1;
				i_delay    = int'(rand_bits(2));
				i_wait     = int'(rand_bits(2));
				if (stores_done && inst_addr == halt_pc) begin
					halt_seen = 1'b1;
				end
			end else begin
				i_wait--;
			end
		end
		if (d_busy) begin
			if (d_delay == 0) begin
				data_valid = 1'b1;
				data_rdata = dmem[d_addr[7:2]];
				d_busy     = 1'b0;
			end else begin
				d_delay--;
			end
		end else if (data_start) begin
			if (d_wait == 0) begin
				data_ready = 1'b1;
				d_wait     = int'(rand_bits(2));
				if (data_write) begin
					take_store(data_addr, data_wdata);
				end else begin
					d_addr  = data_addr;
					d_busy  = 1'b1;
					d_delay = int'(rand_bits(2));
				end
			end else begin
				d_wait--;
			end
		end
	end

	always @(posedge clk) begin
		if (rst_n) begin
			cycles++;
			if (cycles >= max_cycles) begin
				stop_with_failure($sformatf("timeout after %0d cycles, halt loop not reached",
					cycles));
			end
		end
	end

	initial begin
		rst_n       = 1'b0;
		inst_ready  = 1'b0;
		inst_valid  = 1'b0;
		inst_data   = '0;
		data_ready  = 1'b0;
		data_valid  = 1'b0;
		data_rdata  = '0;
		lfsr        = 32'h804cced2;
		cycles      = 0;
		store_cnt   = 0;
		stores_done = 1'b0;
		halt_seen   = 1'b0;
		first_fetch = 1'b0;
		i_busy      = 1'b0;
		i_delay     = 0;
		i_addr      = '0;
		d_busy      = 1'b0;
		d_delay     = 0;
		d_addr      = '0;
		for (int w = 0; w < 64; w++) begin
			dmem[w] = fill_word(32'h400 + 32'(4 * w));
		end
		build_program();
		run_model();
		i_wait = int'(rand_bits(2));
		d_wait = int'(rand_bits(2));
		repeat (16) @(negedge clk);
		check_value("inst_start in reset", 32'd0, {31'd0, inst_start});
		check_value("data_start in reset", 32'd0, {31'd0, data_start});
		rst_n = 1'b1;
		wait (halt_seen);
		// room for a stray store to show up
		repeat (20) @(negedge clk);
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire
